// File: src/rvPkg.sv
package rvPkg;

    // Fixed RV32I widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // funct3 encodings shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 encodings
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcodeE;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB
    } aluOpE;

    // Decode stage output, 118 bits
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        aluOpE                 aluOp;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  useImm;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rs1Data;
        logic [XLEN-1:0]       rs2Data;
    } decodedOpT;

    // Execute result, also used for the write-back port
    typedef struct packed {
        logic                  valid;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } execResultT;

endpackage

// File: src/regFile.sv
module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         we,
    input  logic [rvPkg::REG_ADDR_W-1:0] waddr,
    input  logic [rvPkg::XLEN-1:0]       wdata,
    input  logic [rvPkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rvPkg::REG_ADDR_W-1:0] raddr2,
    output logic [rvPkg::XLEN-1:0]       rdata1,
    output logic [rvPkg::XLEN-1:0]       rdata2
);

    // x0 has no storage
    logic [rvPkg::XLEN-1:0] regs [31:1];

    function automatic logic [rvPkg::XLEN-1:0] readReg(
        input logic [rvPkg::REG_ADDR_W-1:0] addr
    );
        logic [rvPkg::XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && (waddr == addr)) begin
            // Write-through, covers the distance-3 dependency
            value = wdata;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdata1 = readReg(raddr1);
        rdata2 = readReg(raddr2);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: src/resultStage.sv
module resultStage (
    input  logic                         clk,
    input  logic                         rstN,
    input  rvPkg::execResultT            exeRes,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs1Addr,
    input  logic [rvPkg::REG_ADDR_W-1:0] rs2Addr,
    output logic [rvPkg::XLEN-1:0]       rs1Data,
    output logic [rvPkg::XLEN-1:0]       rs2Data,
    output rvPkg::execResultT            wbRes
);

    logic regWe;

    // Write-back register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRes <= '0;
        end else begin
            wbRes <= exeRes;
        end
    end

    // Illegal entries retire without touching the registers
    assign regWe = wbRes.valid && !wbRes.illegal;

    regFile regFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .waddr  (wbRes.rd),
        .wdata  (wbRes.data),
        .raddr1 (rs1Addr),
        .raddr2 (rs2Addr),
        .rdata1 (rs1Data),
        .rdata2 (rs2Data)
    );

endmodule

// File: src/instrDecode.sv
module instrDecode (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         instrValid,
    input  logic [rvPkg::XLEN-1:0]       instr,
    output logic [rvPkg::REG_ADDR_W-1:0] rs1Addr,
    output logic [rvPkg::REG_ADDR_W-1:0] rs2Addr,
    input  logic [rvPkg::XLEN-1:0]       rs1Data,
    input  logic [rvPkg::XLEN-1:0]       rs2Data,
    output rvPkg::decodedOpT             decOp
);

    rvPkg::opcodeE    opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             alt;
    logic             bad;
    rvPkg::decodedOpT dec;

    assign opcode  = rvPkg::opcodeE'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign alt     = instr[30];

    // Register read addresses go straight to the register file
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    always_comb begin
        dec         = '0;
        bad         = 1'b0;
        dec.rd      = instr[11:7];
        dec.rs1     = rs1Addr;
        dec.rs2     = rs2Addr;
        dec.rs1Data = rs1Data;
        dec.rs2Data = rs2Data;
        // I immediate, sign extended
        dec.imm     = {{20{instr[31]}}, instr[31:20]};

        case (funct3)
            rvPkg::F3_ADD:  dec.aluOp = (opcode == rvPkg::OP && alt) ? rvPkg::SUB : rvPkg::ADD;
            rvPkg::F3_SLL:  dec.aluOp = rvPkg::SLL;
            rvPkg::F3_SLT:  dec.aluOp = rvPkg::SLT;
            rvPkg::F3_SLTU: dec.aluOp = rvPkg::SLTU;
            rvPkg::F3_XOR:  dec.aluOp = rvPkg::XOR;
            rvPkg::F3_SR:   dec.aluOp = alt ? rvPkg::SRA : rvPkg::SRL;
            rvPkg::F3_OR:   dec.aluOp = rvPkg::OR;
            default:        dec.aluOp = rvPkg::AND;
        endcase

        case (opcode)
            rvPkg::OP: begin
                // funct7 alt only for sub and sra
                if (funct7 == rvPkg::F7_ALT) begin
                    bad = (funct3 != rvPkg::F3_ADD) && (funct3 != rvPkg::F3_SR);
                end else begin
                    bad = (funct7 != rvPkg::F7_BASE);
                end
            end
            rvPkg::OP_IMM: begin
                dec.useImm = 1'b1;
                if (funct3 == rvPkg::F3_SLL) begin
                    bad = (funct7 != rvPkg::F7_BASE);
                end else if (funct3 == rvPkg::F3_SR) begin
                    bad = (funct7 != rvPkg::F7_BASE) && (funct7 != rvPkg::F7_ALT);
                end
            end
            rvPkg::LUI: begin
                dec.useImm = 1'b1;
                dec.aluOp  = rvPkg::PASSB;
                dec.imm    = {instr[31:12], 12'b0};
            end
            default: begin
                bad = 1'b1;
            end
        endcase

        dec.valid   = instrValid;
        dec.illegal = instrValid && bad;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decOp <= '0;
        end else begin
            decOp <= dec;
        end
    end

endmodule

// File: src/aluExecute.sv
module aluExecute (
    input  logic              clk,
    input  logic              rstN,
    input  rvPkg::decodedOpT  decOp,
    input  rvPkg::execResultT wbRes,
    output rvPkg::execResultT exeRes
);

    logic [rvPkg::XLEN-1:0] srcA;
    logic [rvPkg::XLEN-1:0] srcRegB;
    logic [rvPkg::XLEN-1:0] srcB;
    logic [rvPkg::XLEN-1:0] aluOut;

    // Only entries that will really be written can forward
    function automatic logic [rvPkg::XLEN-1:0] fwdOperand(
        input logic [rvPkg::REG_ADDR_W-1:0] rs,
        input logic [rvPkg::XLEN-1:0]       regData
    );
        logic [rvPkg::XLEN-1:0] value;
        if (exeRes.valid && !exeRes.illegal && (exeRes.rd != '0) && (exeRes.rd == rs)) begin
            value = exeRes.data;
        end else if (wbRes.valid && !wbRes.illegal && (wbRes.rd != '0) && (wbRes.rd == rs)) begin
            value = wbRes.data;
        end else begin
            value = regData;
        end
        return value;
    endfunction

    always_comb begin
        srcA    = fwdOperand(decOp.rs1, decOp.rs1Data);
        srcRegB = fwdOperand(decOp.rs2, decOp.rs2Data);
        srcB    = decOp.useImm ? decOp.imm : srcRegB;
    end

    always_comb begin
        case (decOp.aluOp)
            rvPkg::ADD:   aluOut = srcA + srcB;
            rvPkg::SUB:   aluOut = srcA - srcB;
            rvPkg::SLL:   aluOut = srcA << srcB[4:0];
            rvPkg::SLT:   aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
            rvPkg::SLTU:  aluOut = {31'b0, srcA < srcB};
            rvPkg::XOR:   aluOut = srcA ^ srcB;
            rvPkg::SRL:   aluOut = srcA >> srcB[4:0];
            rvPkg::SRA:   aluOut = $unsigned($signed(srcA) >>> srcB[4:0]);
            rvPkg::OR:    aluOut = srcA | srcB;
            rvPkg::AND:   aluOut = srcA & srcB;
            rvPkg::PASSB: aluOut = srcB;
            default:      aluOut = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeRes <= '0;
        end else begin
            exeRes.valid   <= decOp.valid;
            exeRes.illegal <= decOp.illegal;
            exeRes.rd      <= decOp.rd;
            exeRes.data    <= aluOut;
        end
    end

endmodule

// File: src/riscvCore.sv
module riscvCore (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [rvPkg::XLEN-1:0] instr,
    output rvPkg::execResultT      wb
);

    // Register read path
    logic [rvPkg::REG_ADDR_W-1:0] rs1Addr;
    logic [rvPkg::REG_ADDR_W-1:0] rs2Addr;
    logic [rvPkg::XLEN-1:0]       rs1Data;
    logic [rvPkg::XLEN-1:0]       rs2Data;

    // Pipeline registers
    rvPkg::decodedOpT  decOp;
    rvPkg::execResultT exeRes;
    rvPkg::execResultT wbRes;

    instrDecode instrDecode_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .decOp      (decOp)
    );

    // wbRes doubles as the distance-2 forwarding source
    aluExecute aluExecute_inst (
        .clk    (clk),
        .rstN   (rstN),
        .decOp  (decOp),
        .wbRes  (wbRes),
        .exeRes (exeRes)
    );

    resultStage resultStage_inst (
        .clk     (clk),
        .rstN    (rstN),
        .exeRes  (exeRes),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbRes   (wbRes)
    );

    assign wb = wbRes;

endmodule

// File: dv/riscvCore_properties.sv
module riscvCore_properties (
    input logic                         clk,
    input logic                         rstN,
    input logic                         instrValid,
    input rvPkg::execResultT            wb,
    input logic [rvPkg::REG_ADDR_W-1:0] rs1Addr,
    input logic [rvPkg::REG_ADDR_W-1:0] rs2Addr,
    input logic [rvPkg::XLEN-1:0]       rs1Data,
    input logic [rvPkg::XLEN-1:0]       rs2Data
);

    // Nothing retires while reset is held
    wbIdleInReset: assert property (@(posedge clk) !rstN |-> !wb.valid)
        else $error("wb valid while reset is asserted");

    // Fixed latency, bubbles included
    wbFollowsValid: assert property (@(posedge clk) disable iff (!rstN)
        wb.valid == $past(instrValid, 3))
        else $error("wb valid does not follow instrValid by three cycles");

    // x0 never picks up a written value
    x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
        (wb.valid && !wb.illegal && wb.rd == '0)
            |=> ((rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0)))
        else $error("x0 read returned nonzero data after a write to x0");

endmodule

bind riscvCore riscvCore_properties riscvCore_properties_inst (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .wb         (wb),
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data)
);

// File: dv/riscvCoreTb.sv
module riscvCoreTb;

    // Instruction with the wb it must produce
    typedef struct packed {
        logic                   instrValid;
        logic [rvPkg::XLEN-1:0] instr;
        rvPkg::execResultT      exp;
    } stimT;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic [rvPkg::XLEN-1:0] instr;
    rvPkg::execResultT      wb;

    stimT                   stimTable[$];
    rvPkg::execResultT      expQ[$];
    logic [rvPkg::XLEN-1:0] refRegs [32];
    logic [31:0]            lfsrState;
    int                     cycles = 0;

    riscvCore riscvCore_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::OP};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rvPkg::OP_IMM};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rvPkg::LUI};
    endfunction

    // Architectural RV32I model, one instruction at a time
    task automatic modelInstr(input logic v, input logic [31:0] ins,
                              output rvPkg::execResultT exp);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        isImm;
        logic        bad;
        f7    = ins[31:25];
        f3    = ins[14:12];
        isImm = (ins[6:0] == 7'b0010011);
        a     = refRegs[ins[19:15]];
        b     = isImm ? {{20{ins[31]}}, ins[31:20]} : refRegs[ins[24:20]];
        res   = '0;
        bad   = 1'b0;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0110011, 7'b0010011: begin
                case (f3)
                    3'b000:  res = (!isImm && f7[5]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b011:  res = {31'b0, a < b};
                    3'b100:  res = a ^ b;
                    3'b101:  res = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
                if (isImm) begin
                    bad = (f3 == 3'b001 && f7 != 7'h00) ||
                          (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
                end else begin
                    bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                end
            end
            default: bad = 1'b1;
        endcase
        exp.valid   = v;
        exp.illegal = v && bad;
        exp.rd      = ins[11:7];
        exp.data    = res;
        if (v && !bad && ins[11:7] != 5'd0) begin
            refRegs[ins[11:7]] = res;
        end
    endtask

    task automatic addEntry(input logic v, input logic [31:0] ins);
        stimT              s;
        rvPkg::execResultT exp;
        modelInstr(v, ins, exp);
        s.instrValid = v;
        s.instr      = ins;
        s.exp        = exp;
        stimTable.push_back(s);
    endtask

    task automatic buildDirected();
        // Operands, then each register op with distance 1, 2 and 3 sources
        addEntry(1'b1, iType(12'd5, 5'd0, rvPkg::F3_ADD, 5'd1));
        addEntry(1'b1, iType(12'hffd, 5'd0, rvPkg::F3_ADD, 5'd2));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd2, 5'd1, rvPkg::F3_ADD, 5'd3));
        addEntry(1'b1, rType(rvPkg::F7_ALT, 5'd1, 5'd3, rvPkg::F3_ADD, 5'd4));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_SLL, 5'd5));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_SLT, 5'd6));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_SLTU, 5'd7));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_XOR, 5'd8));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_SR, 5'd9));
        addEntry(1'b1, rType(rvPkg::F7_ALT, 5'd1, 5'd2, rvPkg::F3_SR, 5'd10));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_OR, 5'd11));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd2, rvPkg::F3_AND, 5'd12));
        addEntry(1'b0, 32'hffffffff);
        // Immediate forms
        addEntry(1'b1, iType(12'hfff, 5'd2, rvPkg::F3_SLT, 5'd13));
        addEntry(1'b1, iType(12'hfff, 5'd1, rvPkg::F3_SLTU, 5'd14));
        addEntry(1'b1, iType(12'h0ff, 5'd1, rvPkg::F3_XOR, 5'd15));
        addEntry(1'b1, iType(12'h700, 5'd1, rvPkg::F3_OR, 5'd16));
        addEntry(1'b1, iType(12'h0f0, 5'd2, rvPkg::F3_AND, 5'd17));
        addEntry(1'b1, iType(12'h01f, 5'd1, rvPkg::F3_SLL, 5'd18));
        addEntry(1'b1, iType(12'h004, 5'd2, rvPkg::F3_SR, 5'd19));
        addEntry(1'b1, iType(12'h404, 5'd2, rvPkg::F3_SR, 5'd20));
        // Full constant from lui and addi
        addEntry(1'b1, uType(20'h12345, 5'd21));
        addEntry(1'b1, iType(12'h678, 5'd21, rvPkg::F3_ADD, 5'd21));
        addEntry(1'b0, 32'h00000000);
        addEntry(1'b0, 32'h00000000);
        // x0 target, then x0 read right behind it
        addEntry(1'b1, iType(12'd9, 5'd1, rvPkg::F3_ADD, 5'd0));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd1, 5'd0, rvPkg::F3_ADD, 5'd22));
        // Illegal encodings must leave x1 and x3 alone
        addEntry(1'b1, rType(7'h01, 5'd2, 5'd1, rvPkg::F3_ADD, 5'd1));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd0, 5'd1, rvPkg::F3_ADD, 5'd23));
        addEntry(1'b1, 32'h0000a183);
        addEntry(1'b1, iType(12'h401, 5'd1, rvPkg::F3_SLL, 5'd1));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd0, 5'd3, rvPkg::F3_ADD, 5'd24));
        addEntry(1'b1, rType(rvPkg::F7_BASE, 5'd0, 5'd1, rvPkg::F3_ADD, 5'd25));
    endtask

    // Legal R or I op on x0..x7 so that dependencies are frequent
    task automatic addRandom();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        takeBits(26, r);
        f3  = r[3:1];
        alt = r[4] && (f3 == 3'b101 || (f3 == 3'b000 && !r[0]));
        if (r[0]) begin
            imm = r[25:14];
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm[11:5] = {1'b0, alt, 5'b0};
            end
            addEntry(1'b1, iType(imm, {2'b0, r[10:8]}, f3, {2'b0, r[7:5]}));
        end else begin
            addEntry(1'b1, rType({1'b0, alt, 5'b0}, {2'b0, r[13:11]}, {2'b0, r[10:8]}, f3,
                                 {2'b0, r[7:5]}));
        end
    endtask

    task automatic checkResult(input rvPkg::execResultT exp, input rvPkg::execResultT act);
        logic  ok;
        string expStr;
        string actStr;
        ok = (act.valid === exp.valid);
        if (exp.valid) begin
            ok = ok && (act.illegal === exp.illegal) && (act.rd === exp.rd);
        end
        if (exp.valid && !exp.illegal) begin
            ok = ok && (act.data === exp.data);
        end
        if (!ok) begin
            expStr = $sformatf("v=%b ill=%b rd=%0d data=%h",
                               exp.valid, exp.illegal, exp.rd, exp.data);
            actStr = $sformatf("v=%b ill=%b rd=%0d data=%h",
                               act.valid, act.illegal, act.rd, act.data);
            $display("** Error at %0t: wb expected %s, got %s", $time, expStr, actStr);
            $display("sim failed");
            $fatal(1, "wb mismatch");
        end
    endtask

    // Table, reset, latency, then some slack
    function automatic int cycleLimit();
        return stimTable.size() + 16 + 3 + 20;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit()) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit());
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    // wb for the entry driven three edges ago
    always @(negedge clk) begin
        if (expQ.size() == 4) begin
            checkResult(expQ.pop_front(), wb);
        end
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        lfsrState  = 32'h83bb0f53;
        refRegs    = '{default: '0};
        buildDirected();
        repeat (64) addRandom();
        repeat (3) addEntry(1'b0, 32'h00000000);
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        foreach (stimTable[i]) begin
            @(posedge clk);
            instrValid <= stimTable[i].instrValid;
            instr      <= stimTable[i].instr;
            expQ.push_back(stimTable[i].exp);
        end
        repeat (2) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: compile.f
src/rvPkg.sv
src/regFile.sv
src/resultStage.sv
src/instrDecode.sv
src/aluExecute.sv
src/riscvCore.sv
dv/riscvCore_properties.sv
dv/riscvCoreTb.sv

// File: Makefile
TOP := riscvCoreTb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f src/*.sv dv/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
